// ==== verilog/dsp_mac_config.svh ====
`ifndef DSP_MAC_CONFIG_SVH
`define DSP_MAC_CONFIG_SVH

// Operand widths of the multiplier
`define DSP_A_WIDTH 20
`define DSP_B_WIDTH 18

// Accumulator holds the full product plus growth headroom
`define DSP_ACC_WIDTH 64

// Registered result width
`define DSP_Z_WIDTH 38

// Right shift amount, 0 to 63
`define DSP_SHIFT_WIDTH 6

`endif

// ==== verilog/dsp_mac_pkg.sv ====
package dsp_mac_pkg;

`include "dsp_mac_config.svh"

    // Run-time operation of the accumulator
    typedef enum logic [1:0] {
        DSP_OP_MULT     = 2'd0,
        DSP_OP_MAC      = 2'd1,
        DSP_OP_MAC_INIT = 2'd2
    } dsp_op_e;

    typedef logic [`DSP_A_WIDTH-1:0]     dsp_a_t;
    typedef logic [`DSP_B_WIDTH-1:0]     dsp_b_t;
    typedef logic [`DSP_ACC_WIDTH-1:0]   dsp_acc_t;
    typedef logic [`DSP_Z_WIDTH-1:0]     dsp_z_t;
    typedef logic [`DSP_SHIFT_WIDTH-1:0] dsp_shift_t;

endpackage

// ==== verilog/dsp_input_reg.sv ====
`timescale 1ns/100ps

module dsp_input_reg
    import dsp_mac_pkg::*;
(
    input  logic       clock_i,
    input  logic       s_reset,
    input  logic       valid_i,
    input  dsp_op_e    op_i,
    input  dsp_a_t     a_i,
    input  dsp_b_t     b_i,
    input  logic       unsigned_a_i,
    input  logic       unsigned_b_i,
    input  logic       subtract_i,
    input  logic       round_i,
    input  logic       saturate_i,
    input  dsp_shift_t shift_right_i,
    output logic       valid_o,
    output dsp_op_e    op_o,
    output dsp_a_t     a_o,
    output dsp_b_t     b_o,
    output logic       unsigned_a_o,
    output logic       unsigned_b_o,
    output logic       subtract_o,
    output logic       round_o,
    output logic       saturate_o,
    output dsp_shift_t shift_right_o
);

    // First pipeline stage that loads every cycle
    always_ff @(posedge clock_i or posedge s_reset) begin
        if (s_reset) begin
            valid_o       <= 1'b0;
            op_o          <= DSP_OP_MULT;
            a_o           <= '0;
            b_o           <= '0;
            unsigned_a_o  <= 1'b0;
            unsigned_b_o  <= 1'b0;
            subtract_o    <= 1'b0;
            round_o       <= 1'b0;
            saturate_o    <= 1'b0;
            shift_right_o <= '0;
        end else begin
            valid_o       <= valid_i;
            op_o          <= op_i;
            a_o           <= a_i;
            b_o           <= b_i;
            unsigned_a_o  <= unsigned_a_i;
            unsigned_b_o  <= unsigned_b_i;
            subtract_o    <= subtract_i;
            round_o       <= round_i;
            saturate_o    <= saturate_i;
            shift_right_o <= shift_right_i;
        end
    end

    // Encoding 3 is never legal downstream
    op_legal_a: assert property (@(posedge clock_i) disable iff (s_reset)
        op_o inside {DSP_OP_MULT, DSP_OP_MAC, DSP_OP_MAC_INIT});

endmodule

// ==== verilog/dsp_multiplier.sv ====
`timescale 1ns/100ps
`include "dsp_mac_config.svh"

module dsp_multiplier
    import dsp_mac_pkg::*;
(
    input  dsp_a_t   a_i,
    input  dsp_b_t   b_i,
    input  logic     unsigned_a_i,
    input  logic     unsigned_b_i,
    output dsp_acc_t product_o
);

    localparam int A_W    = `DSP_A_WIDTH;
    localparam int B_W    = `DSP_B_WIDTH;
    localparam int PROD_W = `DSP_A_WIDTH + `DSP_B_WIDTH;
    localparam int EXT_W  = `DSP_ACC_WIDTH - PROD_W;

    logic signed [A_W:0]      a_ext;
    logic signed [B_W:0]      b_ext;
    logic signed [PROD_W+1:0] prod_full;
    logic [PROD_W-1:0]        prod;
    logic                     unsigned_mode;

    // An unsigned operand gets a zero guard bit and stays non-negative
    assign a_ext = {a_i[A_W-1] & ~unsigned_a_i, a_i};
    assign b_ext = {b_i[B_W-1] & ~unsigned_b_i, b_i};

    assign prod_full = a_ext * b_ext;

    // Every operand combination fits in the low PROD_W bits
    assign prod = prod_full[PROD_W-1:0];

    assign unsigned_mode = unsigned_a_i & unsigned_b_i;

    assign product_o = unsigned_mode ? {{EXT_W{1'b0}}, prod}
                                     : {{EXT_W{prod[PROD_W-1]}}, prod};

endmodule

// ==== verilog/dsp_accumulator.sv ====
`timescale 1ns/100ps

module dsp_accumulator
    import dsp_mac_pkg::*;
(
    input  logic     clock_i,
    input  logic     s_reset,
    input  logic     valid_i,
    input  logic     subtract_i,
    input  dsp_op_e  op_i,
    input  dsp_acc_t product_i,
    output dsp_acc_t sum_o
);

    dsp_acc_t acc_q;
    dsp_acc_t addend;
    dsp_acc_t augend;
    logic     acc_load;

    // Two's complement negation for subtract
    assign addend = subtract_i ? (~product_i + 1'b1) : product_i;

    // Only a plain MAC reads the running value
    assign augend = (op_i == DSP_OP_MAC) ? acc_q : '0;

    assign sum_o = augend + addend;

    assign acc_load = valid_i && (op_i == DSP_OP_MAC || op_i == DSP_OP_MAC_INIT);

    always_ff @(posedge clock_i or posedge s_reset) begin
        if (s_reset) begin
            acc_q <= '0;
        end else if (acc_load) begin
            acc_q <= sum_o;
        end
    end

    // Bubbles in the stream must leave the running sum alone
    acc_hold_a: assert property (@(posedge clock_i) disable iff (s_reset)
        !valid_i |=> $stable(acc_q));

endmodule

// ==== verilog/dsp_output_stage.sv ====
`timescale 1ns/100ps
`include "dsp_mac_config.svh"

module dsp_output_stage
    import dsp_mac_pkg::*;
(
    input  logic       clock_i,
    input  logic       s_reset,
    input  logic       valid_i,
    input  logic       round_i,
    input  logic       saturate_i,
    input  logic       unsigned_mode_i,
    input  dsp_shift_t shift_right_i,
    input  dsp_acc_t   sum_i,
    output dsp_z_t     z_o,
    output logic       valid_o
);

    localparam int ACC_W = `DSP_ACC_WIDTH;
    localparam int Z_W   = `DSP_Z_WIDTH;

    localparam dsp_z_t U_MAX = {Z_W{1'b1}};
    localparam dsp_z_t S_MAX = {1'b0, {(Z_W-1){1'b1}}};
    localparam dsp_z_t S_MIN = {1'b1, {(Z_W-1){1'b0}}};

    logic signed [ACC_W-1:0] shifted;
    logic                    round_inc;
    dsp_acc_t                rounded;
    dsp_z_t                  sat_u;
    dsp_z_t                  sat_s;
    logic                    s_in_range;
    dsp_z_t                  z_next;

    assign shifted = $signed(sum_i) >>> shift_right_i;

    // Round half up on the last bit shifted out
    assign round_inc = round_i && (shift_right_i != '0) && sum_i[shift_right_i - 1'b1];
    assign rounded   = shifted + {{(ACC_W-1){1'b0}}, round_inc};

    // Unsigned clamp to [0, 2^Z_W - 1]
    assign sat_u = rounded[ACC_W-1]        ? '0    :
                   (|rounded[ACC_W-1:Z_W]) ? U_MAX :
                                             rounded[Z_W-1:0];

    // Signed value fits when all bits above the sign bit match it
    assign s_in_range = ~|rounded[ACC_W-1:Z_W-1] || &rounded[ACC_W-1:Z_W-1];
    assign sat_s = s_in_range        ? rounded[Z_W-1:0] :
                   rounded[ACC_W-1]  ? S_MIN            :
                                       S_MAX;

    assign z_next = !saturate_i     ? rounded[Z_W-1:0] :
                    unsigned_mode_i ? sat_u            :
                                      sat_s;

    always_ff @(posedge clock_i or posedge s_reset) begin
        if (s_reset) begin
            z_o     <= '0;
            valid_o <= 1'b0;
        end else begin
            z_o     <= z_next;
            valid_o <= valid_i;
        end
    end

    // A signed clamp keeps the sign of the value it clamps
    sat_sign_a: assert property (@(posedge clock_i) disable iff (s_reset)
        (valid_i && saturate_i && !unsigned_mode_i)
            |=> valid_o && (z_o[Z_W-1] == $past(rounded[ACC_W-1])));

endmodule

// ==== verilog/dsp_mac_top.sv ====
`timescale 1ns/100ps

module dsp_mac_top
    import dsp_mac_pkg::*;
(
    input  logic       clock_i,
    input  logic       s_reset,
    input  logic       valid_i,
    input  dsp_op_e    op_i,
    input  dsp_a_t     a_i,
    input  dsp_b_t     b_i,
    input  logic       unsigned_a_i,
    input  logic       unsigned_b_i,
    input  logic       subtract_i,
    input  logic       round_i,
    input  logic       saturate_i,
    input  dsp_shift_t shift_right_i,
    output dsp_z_t     z_o,
    output logic       valid_o
);

    logic       r_valid;
    dsp_op_e    r_op;
    dsp_a_t     r_a;
    dsp_b_t     r_b;
    logic       r_unsigned_a;
    logic       r_unsigned_b;
    logic       r_subtract;
    logic       r_round;
    logic       r_saturate;
    dsp_shift_t r_shift_right;
    logic       unsigned_mode;
    dsp_acc_t   product;
    dsp_acc_t   sum;

    // Both operands unsigned selects the unsigned result path
    assign unsigned_mode = r_unsigned_a & r_unsigned_b;

    dsp_input_reg u_input_reg (
        .clock_i      (clock_i),
        .s_reset      (s_reset),
        .valid_i      (valid_i),
        .op_i         (op_i),
        .a_i          (a_i),
        .b_i          (b_i),
        .unsigned_a_i (unsigned_a_i),
        .unsigned_b_i (unsigned_b_i),
        .subtract_i   (subtract_i),
        .round_i      (round_i),
        .saturate_i   (saturate_i),
        .shift_right_i(shift_right_i),
        .valid_o      (r_valid),
        .op_o         (r_op),
        .a_o          (r_a),
        .b_o          (r_b),
        .unsigned_a_o (r_unsigned_a),
        .unsigned_b_o (r_unsigned_b),
        .subtract_o   (r_subtract),
        .round_o      (r_round),
        .saturate_o   (r_saturate),
        .shift_right_o(r_shift_right)
    );

    dsp_multiplier u_multiplier (
        .a_i         (r_a),
        .b_i         (r_b),
        .unsigned_a_i(r_unsigned_a),
        .unsigned_b_i(r_unsigned_b),
        .product_o   (product)
    );

    dsp_accumulator u_accumulator (
        .clock_i   (clock_i),
        .s_reset   (s_reset),
        .valid_i   (r_valid),
        .subtract_i(r_subtract),
        .op_i      (r_op),
        .product_i (product),
        .sum_o     (sum)
    );

    dsp_output_stage u_output_stage (
        .clock_i        (clock_i),
        .s_reset        (s_reset),
        .valid_i        (r_valid),
        .round_i        (r_round),
        .saturate_i     (r_saturate),
        .unsigned_mode_i(unsigned_mode),
        .shift_right_i  (r_shift_right),
        .sum_i          (sum),
        .z_o            (z_o),
        .valid_o        (valid_o)
    );

endmodule

// ==== verif/dsp_mac_tb.sv ====
`timescale 1ns/100ps

module dsp_mac_tb
    import dsp_mac_pkg::*;
();

    localparam int NUM_LINES    = 32;
    localparam int LINE_W       = 116;
    localparam int RESET_CYCLES = 3;
    localparam int LATENCY      = 2;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + NUM_LINES + 20;

    logic       clock_i = 1'b0;
    logic       s_reset;
    logic       valid_i;
    dsp_op_e    op_i;
    dsp_a_t     a_i;
    dsp_b_t     b_i;
    logic       unsigned_a_i;
    logic       unsigned_b_i;
    logic       subtract_i;
    logic       round_i;
    logic       saturate_i;
    dsp_shift_t shift_right_i;
    dsp_z_t     z_o;
    logic       valid_o;

    logic [LINE_W-1:0] stim_mem [NUM_LINES];
    dsp_z_t            exp_z_q[$];
    int                exp_cycle_q[$];
    int                cycle_count = 0;

    dsp_mac_top dut_i (
        .clock_i      (clock_i),
        .s_reset      (s_reset),
        .valid_i      (valid_i),
        .op_i         (op_i),
        .a_i          (a_i),
        .b_i          (b_i),
        .unsigned_a_i (unsigned_a_i),
        .unsigned_b_i (unsigned_b_i),
        .subtract_i   (subtract_i),
        .round_i      (round_i),
        .saturate_i   (saturate_i),
        .shift_right_i(shift_right_i),
        .z_o          (z_o),
        .valid_o      (valid_o)
    );

    initial begin
        forever #4 clock_i = ~clock_i;
    end

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("error at %0t: %s expected %h, got %h", $time, what, expected, actual);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    always @(posedge clock_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: results still pending after %0d cycles", cycle_count);
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    // Outputs are sampled half a cycle after the edge that registers them
    always @(negedge clock_i) begin
        if (valid_o !== 1'b0) begin
            if (exp_z_q.size() == 0) begin
                $display("Unexpected output: valid_o is %b with no sample in flight", valid_o);
                $display("TEST FAILED");
                $fatal(1);
            end else begin
                check_value(cycle_count, exp_cycle_q.pop_front(), "output cycle");
                check_value(z_o, exp_z_q.pop_front(), "z_o");
            end
        end
    end

    initial begin
        logic [LINE_W-1:0] line;
        int                i;

        s_reset       = 1'b1;
        valid_i       = 1'b0;
        op_i          = DSP_OP_MULT;
        a_i           = '0;
        b_i           = '0;
        unsigned_a_i  = 1'b0;
        unsigned_b_i  = 1'b0;
        subtract_i    = 1'b0;
        round_i       = 1'b0;
        saturate_i    = 1'b0;
        shift_right_i = '0;

        $readmemh("verif/dsp_mac_input.txt", stim_mem);
        for (i = 0; i < NUM_LINES; i++) begin
            if ($isunknown(stim_mem[i])) begin
                $display("Stimulus file has fewer than %0d readable lines", NUM_LINES);
                $display("TEST FAILED");
                $fatal(1);
            end
        end

        repeat (RESET_CYCLES) @(posedge clock_i);
        s_reset <= 1'b0;

        // Field layout follows the column header of the data file
        for (i = 0; i < NUM_LINES; i++) begin
            @(posedge clock_i);
            line = stim_mem[i];
            valid_i       <= line[112];
            op_i          <= dsp_op_e'(line[109:108]);
            a_i           <= line[107:88];
            b_i           <= line[85:68];
            unsigned_a_i  <= line[64];
            unsigned_b_i  <= line[60];
            subtract_i    <= line[56];
            shift_right_i <= line[53:48];
            round_i       <= line[44];
            saturate_i    <= line[40];
            if (line[112]) begin
                exp_z_q.push_back(line[37:0]);
                // Registered at the next edge and out LATENCY edges after that
                exp_cycle_q.push_back(cycle_count + 1 + LATENCY);
            end
        end

        @(posedge clock_i);
        valid_i <= 1'b0;
        while (exp_z_q.size() != 0) begin
            @(posedge clock_i);
        end
        // A few idle cycles catch a stray valid_o
        repeat (4) @(posedge clock_i);
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== dsp_mac.f ====
+incdir+verilog
verilog/dsp_mac_pkg.sv
verilog/dsp_input_reg.sv
verilog/dsp_multiplier.sv
verilog/dsp_accumulator.sv
verilog/dsp_output_stage.sv
verilog/dsp_mac_top.sv
verif/dsp_mac_tb.sv

// ==== Bender.yml ====
package:
  name: dsp_mac

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/dsp_mac_pkg.sv
      - verilog/dsp_input_reg.sv
      - verilog/dsp_multiplier.sv
      - verilog/dsp_accumulator.sv
      - verilog/dsp_output_stage.sv
      - verilog/dsp_mac_top.sv
  - target: test
    files:
      - verif/dsp_mac_tb.sv

// ==== verif/dsp_mac_input.txt ====
// valid op a b unsigned_a unsigned_b subtract shift round saturate expected_z
// All hex, op 0 mult 1 mac 2 mac_init, z is the low 38 bits of the result
0_0_00000_00000_0_0_0_00_0_0_0000000000
1_0_00003_00005_0_0_0_00_0_0_000000000f
1_0_fffff_00002_0_0_0_00_0_0_3ffffffffe
1_0_80000_20000_0_0_0_00_0_0_1000000000
1_0_fffff_3ffff_1_1_0_00_0_0_3fffec0001
1_0_fffff_3ffff_1_0_0_00_0_0_3ffff00001
1_0_80000_3ffff_0_1_0_00_0_0_2000080000
1_2_00064_00003_0_0_0_00_0_0_000000012c
1_1_00010_00010_0_0_0_00_0_0_000000022c
0_1_12345_00777_0_0_0_00_0_0_0000000000
1_1_00005_00064_0_0_1_00_0_0_0000000038
1_1_00002_00040_0_0_1_00_0_0_3fffffffb8
1_1_00001_00100_0_0_0_00_0_0_00000000b8
1_2_00003_00001_0_0_0_01_0_0_0000000001
1_2_00003_00001_0_0_0_01_1_0_0000000002
1_1_00001_00002_0_0_0_00_1_0_0000000005
1_2_00c00_00001_0_0_0_0a_1_0_0000000003
1_2_00e00_00001_0_0_0_0a_1_0_0000000004
1_2_00e00_00001_0_0_0_0a_0_0_0000000003
1_2_fffff_00600_0_0_0_0a_1_0_3fffffffff
1_2_80000_20000_0_0_0_00_0_1_1000000000
1_1_80000_20000_0_0_0_00_0_1_1fffffffff
1_1_80000_20000_0_0_0_00_0_0_3000000000
1_2_80000_20000_0_0_1_00_0_1_3000000000
1_1_80000_20000_0_0_1_00_0_1_2000000000
1_1_80000_20000_0_0_1_00_0_1_2000000000
1_1_80000_20000_0_0_1_00_0_0_0000000000
1_0_00001_00001_1_1_1_00_0_1_0000000000
1_0_00001_00001_1_1_1_00_0_0_3fffffffff
1_2_fffff_3ffff_1_1_0_00_0_1_3fffec0001
1_1_fffff_3ffff_1_1_0_00_0_1_3fffffffff
1_1_fffff_3ffff_1_1_0_00_0_0_3fffc40003
